// File: include/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ######################################################################
// bus widths
// ######################################################################
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_ID_W 4
`define SOC_STRB_W 8
`define SOC_LEN_W 8

// ######################################################################
// memory map
// ######################################################################
`define REGION_SRAM 4'h8
`define REGION_UART 4'h1
`define SRAM_WORDS 256
`define SRAM_IDX_W 8  // log2 of SRAM_WORDS.

// ######################################################################
// peripherals
// ######################################################################
`define UART_CLKS_PER_BIT 16  // small to keep simulation short.
`define HEARTBEAT_HALF 13_499_999  // half a second at 27 MHz.

`endif

// File: src/axi_pkg.sv
`default_nettype none

package axi_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

endpackage

`default_nettype wire

// File: src/soc_pkg.sv
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

  typedef logic [3:0] region_t;

  // one address word, seen as a memory word or as a register slot.
  typedef union packed {
    struct packed {
      region_t                 region;
      logic [`SOC_ADDR_W-8-`SRAM_IDX_W:0] unused;
      logic [`SRAM_IDX_W-1:0] word;
      logic [2:0]              offset;
    } mem;
    struct packed {
      region_t               region;
      logic [`SOC_ADDR_W-10:0] unused;
      logic [1:0]            idx;
      logic [2:0]            offset;
    } regs;
  } bus_addr_t;

  typedef enum logic [1:0] {
    TXDATA = 2'd0,
    RXDATA = 2'd1,
    STATUS = 2'd2
  } uart_reg_t;

endpackage

`default_nettype wire

// File: src/axi_addr_decoder.sv
`default_nettype none

`include "soc_consts.svh"

module axi_addr_decoder (
  input  wire                   clock,
  input  wire                   rst_n,
  input  wire                   m_aw_valid,
  input  wire [`SOC_ID_W-1:0]   m_aw_id,
  input  wire [`SOC_ADDR_W-1:0] m_aw_addr,
  input  wire [`SOC_LEN_W-1:0]  m_aw_len,
  input  wire [1:0]             m_aw_burst,
  output logic                  m_aw_ready,
  input  wire                   m_w_valid,
  input  wire [`SOC_DATA_W-1:0] m_w_data,
  input  wire [`SOC_STRB_W-1:0] m_w_strb,
  input  wire                   m_w_last,
  output logic                  m_w_ready,
  input  wire                   m_b_ready,
  output logic                  m_b_valid,
  output logic [`SOC_ID_W-1:0]  m_b_id,
  output logic [1:0]            m_b_resp,
  input  wire                   m_ar_valid,
  input  wire [`SOC_ID_W-1:0]   m_ar_id,
  input  wire [`SOC_ADDR_W-1:0] m_ar_addr,
  input  wire [`SOC_LEN_W-1:0]  m_ar_len,
  input  wire [1:0]             m_ar_burst,
  output logic                  m_ar_ready,
  input  wire                   m_r_ready,
  output logic                  m_r_valid,
  output logic [`SOC_ID_W-1:0]  m_r_id,
  output logic [`SOC_DATA_W-1:0] m_r_data,
  output logic [1:0]            m_r_resp,
  output logic                  m_r_last,
  // downstream index 0 is SRAM and index 1 is UART.
  output logic [1:0]            s_aw_valid,
  output wire [`SOC_ID_W-1:0]   s_aw_id,
  output wire [`SOC_ADDR_W-1:0] s_aw_addr,
  output wire [`SOC_LEN_W-1:0]  s_aw_len,
  output wire [1:0]             s_aw_burst,
  input  wire [1:0]             s_aw_ready,
  output logic [1:0]            s_w_valid,
  output wire [`SOC_DATA_W-1:0] s_w_data,
  output wire [`SOC_STRB_W-1:0] s_w_strb,
  output wire                   s_w_last,
  input  wire [1:0]             s_w_ready,
  output logic [1:0]            s_b_ready,
  input  wire [1:0]             s_b_valid,
  input  wire [2*`SOC_ID_W-1:0] s_b_id,
  input  wire [3:0]             s_b_resp,
  output logic [1:0]            s_ar_valid,
  output wire [`SOC_ID_W-1:0]   s_ar_id,
  output wire [`SOC_ADDR_W-1:0] s_ar_addr,
  output wire [`SOC_LEN_W-1:0]  s_ar_len,
  output wire [1:0]             s_ar_burst,
  input  wire [1:0]             s_ar_ready,
  output logic [1:0]            s_r_ready,
  input  wire [1:0]             s_r_valid,
  input  wire [2*`SOC_ID_W-1:0] s_r_id,
  input  wire [2*`SOC_DATA_W-1:0] s_r_data,
  input  wire [3:0]             s_r_resp,
  input  wire [1:0]             s_r_last
);

  localparam int SEL_ERR = 2;  // anything not 0 or 1.

  soc_pkg::bus_addr_t aw_a;
  soc_pkg::bus_addr_t ar_a;
  logic [1:0] aw_sel_now, ar_sel_now, w_sel, r_sel;
  logic w_busy, r_busy;
  logic err_b_valid, err_r_valid;
  logic [`SOC_ID_W-1:0] err_w_id, err_r_id;
  logic [`SOC_LEN_W-1:0] err_r_cnt;

  function automatic logic [1:0] region_sel(input soc_pkg::region_t rg);
    if (rg == `REGION_SRAM) return 2'd0;
    if (rg == `REGION_UART) return 2'd1;
    return 2'(SEL_ERR);
  endfunction

  assign aw_a = m_aw_addr;
  assign ar_a = m_ar_addr;
  assign aw_sel_now = region_sel(aw_a.mem.region);
  assign ar_sel_now = region_sel(ar_a.mem.region);

  // payloads fan out to both targets while valids and readies are steered.
  assign s_aw_id = m_aw_id;
  assign s_aw_addr = m_aw_addr;
  assign s_aw_len = m_aw_len;
  assign s_aw_burst = m_aw_burst;
  assign s_w_data = m_w_data;
  assign s_w_strb = m_w_strb;
  assign s_w_last = m_w_last;
  assign s_ar_id = m_ar_id;
  assign s_ar_addr = m_ar_addr;
  assign s_ar_len = m_ar_len;
  assign s_ar_burst = m_ar_burst;

  // ######################################################################
  // write channels
  // ######################################################################
  always_comb begin
    s_aw_valid = '0;
    s_w_valid = '0;
    s_b_ready = '0;
    m_aw_ready = !w_busy;
    if (aw_sel_now != 2'(SEL_ERR)) begin
      s_aw_valid[aw_sel_now[0]] = m_aw_valid && !w_busy;
      m_aw_ready = !w_busy && s_aw_ready[aw_sel_now[0]];
    end
    if (w_sel != 2'(SEL_ERR)) begin
      s_w_valid[w_sel[0]] = m_w_valid && w_busy;
      s_b_ready[w_sel[0]] = m_b_ready && w_busy;
      m_w_ready = w_busy && s_w_ready[w_sel[0]];
      m_b_valid = s_b_valid[w_sel[0]];
      m_b_id = s_b_id[w_sel[0]*`SOC_ID_W +: `SOC_ID_W];
      m_b_resp = s_b_resp[w_sel[0]*2 +: 2];
    end else begin
      m_w_ready = w_busy && !err_b_valid;
      m_b_valid = err_b_valid;
      m_b_id = err_w_id;
      m_b_resp = axi_pkg::DECERR;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      w_busy <= 1'b0;
      w_sel <= 2'(SEL_ERR);
      err_b_valid <= 1'b0;
      err_w_id <= '0;
    end else begin
      if (m_aw_valid && m_aw_ready) begin
        w_busy <= 1'b1;
        w_sel <= aw_sel_now;
        err_w_id <= m_aw_id;
      end
      if (w_sel == 2'(SEL_ERR) && m_w_valid && m_w_ready && m_w_last)
        err_b_valid <= 1'b1;
      if (m_b_valid && m_b_ready) begin
        w_busy <= 1'b0;
        err_b_valid <= 1'b0;
      end
    end
  end

  // ######################################################################
  // read channels
  // ######################################################################
  always_comb begin
    s_ar_valid = '0;
    s_r_ready = '0;
    m_ar_ready = !r_busy;
    if (ar_sel_now != 2'(SEL_ERR)) begin
      s_ar_valid[ar_sel_now[0]] = m_ar_valid && !r_busy;
      m_ar_ready = !r_busy && s_ar_ready[ar_sel_now[0]];
    end
    if (r_sel != 2'(SEL_ERR)) begin
      s_r_ready[r_sel[0]] = m_r_ready && r_busy;
      m_r_valid = s_r_valid[r_sel[0]];
      m_r_id = s_r_id[r_sel[0]*`SOC_ID_W +: `SOC_ID_W];
      m_r_data = s_r_data[r_sel[0]*`SOC_DATA_W +: `SOC_DATA_W];
      m_r_resp = s_r_resp[r_sel[0]*2 +: 2];
      m_r_last = s_r_last[r_sel[0]];
    end else begin
      m_r_valid = err_r_valid;
      m_r_id = err_r_id;
      m_r_data = '0;
      m_r_resp = axi_pkg::DECERR;
      m_r_last = (err_r_cnt == '0);
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      r_busy <= 1'b0;
      r_sel <= 2'(SEL_ERR);
      err_r_valid <= 1'b0;
      err_r_id <= '0;
      err_r_cnt <= '0;
    end else begin
      if (m_ar_valid && m_ar_ready) begin
        r_busy <= 1'b1;
        r_sel <= ar_sel_now;
        err_r_id <= m_ar_id;
        err_r_cnt <= m_ar_len;
        err_r_valid <= (ar_sel_now == 2'(SEL_ERR));
      end
      if (r_sel == 2'(SEL_ERR) && err_r_valid && m_r_ready && !m_r_last)
        err_r_cnt <= err_r_cnt - 1'b1;  // beats left.
      if (m_r_valid && m_r_ready && m_r_last) begin
        r_busy <= 1'b0;
        err_r_valid <= 1'b0;
      end
    end
  end

  a_b_in_flight: assert property (@(posedge clock) disable iff (!rst_n)
    m_b_valid |-> w_busy);
  a_r_in_flight: assert property (@(posedge clock) disable iff (!rst_n)
    m_r_valid |-> r_busy);

endmodule

`default_nettype wire

// File: src/axi_sram.sv
`default_nettype none

`include "soc_consts.svh"

module axi_sram (
  input  wire                   clock,
  input  wire                   rst_n,
  input  wire                   aw_valid,
  input  wire [`SOC_ID_W-1:0]   aw_id,
  input  wire [`SOC_ADDR_W-1:0] aw_addr,
  input  wire [`SOC_LEN_W-1:0]  aw_len,
  input  wire [1:0]             aw_burst,
  output wire                   aw_ready,
  input  wire                   w_valid,
  input  wire [`SOC_DATA_W-1:0] w_data,
  input  wire [`SOC_STRB_W-1:0] w_strb,
  input  wire                   w_last,
  output wire                   w_ready,
  input  wire                   b_ready,
  output logic                  b_valid,
  output logic [`SOC_ID_W-1:0]  b_id,
  output logic [1:0]            b_resp,
  input  wire                   ar_valid,
  input  wire [`SOC_ID_W-1:0]   ar_id,
  input  wire [`SOC_ADDR_W-1:0] ar_addr,
  input  wire [`SOC_LEN_W-1:0]  ar_len,
  input  wire [1:0]             ar_burst,
  output wire                   ar_ready,
  input  wire                   r_ready,
  output logic                  r_valid,
  output logic [`SOC_ID_W-1:0]  r_id,
  output logic [`SOC_DATA_W-1:0] r_data,
  output logic [1:0]            r_resp,
  output wire                   r_last
);

  logic [`SOC_DATA_W-1:0] mem [`SRAM_WORDS];
  soc_pkg::bus_addr_t aw_a;
  soc_pkg::bus_addr_t ar_a;
  logic w_active;
  logic [`SRAM_IDX_W-1:0] w_idx, r_idx;
  logic [`SOC_LEN_W-1:0] w_cnt, w_len, r_cnt, r_len;
  logic w_bad;

  assign aw_a = aw_addr;
  assign ar_a = ar_addr;
  assign aw_ready = !w_active && !b_valid;
  assign w_ready = w_active;
  assign ar_ready = !r_valid;
  assign r_last = (r_cnt == r_len);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      w_active <= 1'b0;
      b_valid <= 1'b0;
      w_idx <= '0;
      w_cnt <= '0;
      w_len <= '0;
      w_bad <= 1'b0;
      b_id <= '0;
      b_resp <= axi_pkg::OKAY;
    end else begin
      if (aw_valid && aw_ready) begin
        w_active <= 1'b1;
        w_idx <= aw_a.mem.word;
        w_cnt <= '0;
        w_len <= aw_len;
        w_bad <= (aw_burst != axi_pkg::INCR);  // only INCR is served.
        b_id <= aw_id;
      end
      if (w_valid && w_ready) begin
        w_idx <= w_idx + 1'b1;
        w_cnt <= w_cnt + 1'b1;
        if (w_last) begin
          w_active <= 1'b0;
          b_valid <= 1'b1;
          b_resp <= w_bad ? axi_pkg::SLVERR : axi_pkg::OKAY;
        end
      end
      if (b_valid && b_ready) b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (w_valid && w_ready)
      for (int i = 0; i < `SOC_STRB_W; i++)
        if (w_strb[i]) mem[w_idx][8*i +: 8] <= w_data[8*i +: 8];
  end

  // read data is registered so it holds under a stall.
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
      r_idx <= '0;
      r_cnt <= '0;
      r_len <= '0;
      r_id <= '0;
      r_resp <= axi_pkg::OKAY;
    end else if (ar_valid && ar_ready) begin
      r_valid <= 1'b1;
      r_idx <= ar_a.mem.word + 1'b1;
      r_cnt <= '0;
      r_len <= ar_len;
      r_id <= ar_id;
      r_resp <= (ar_burst == axi_pkg::INCR) ? axi_pkg::OKAY : axi_pkg::SLVERR;
    end else if (r_valid && r_ready) begin
      if (r_last) begin
        r_valid <= 1'b0;
      end else begin
        r_idx <= r_idx + 1'b1;
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_valid && ar_ready) r_data <= mem[ar_a.mem.word];
    else if (r_valid && r_ready && !r_last) r_data <= mem[r_idx];
  end

  a_wlast_on_len: assert property (@(posedge clock) disable iff (!rst_n)
    (w_valid && w_ready) |-> (w_last == (w_cnt == w_len)));

endmodule

`default_nettype wire

// File: src/axi_uart.sv
`default_nettype none

`include "soc_consts.svh"

module axi_uart (
  input  wire                   clock,
  input  wire                   rst_n,
  input  wire                   aw_valid,
  input  wire [`SOC_ID_W-1:0]   aw_id,
  input  wire [`SOC_ADDR_W-1:0] aw_addr,
  input  wire [`SOC_LEN_W-1:0]  aw_len,
  input  wire [1:0]             aw_burst,
  output wire                   aw_ready,
  input  wire                   w_valid,
  input  wire [`SOC_DATA_W-1:0] w_data,
  input  wire [`SOC_STRB_W-1:0] w_strb,
  input  wire                   w_last,
  output wire                   w_ready,
  input  wire                   b_ready,
  output logic                  b_valid,
  output logic [`SOC_ID_W-1:0]  b_id,
  output logic [1:0]            b_resp,
  input  wire                   ar_valid,
  input  wire [`SOC_ID_W-1:0]   ar_id,
  input  wire [`SOC_ADDR_W-1:0] ar_addr,
  input  wire [`SOC_LEN_W-1:0]  ar_len,
  input  wire [1:0]             ar_burst,
  output wire                   ar_ready,
  input  wire                   r_ready,
  output logic                  r_valid,
  output logic [`SOC_ID_W-1:0]  r_id,
  output logic [`SOC_DATA_W-1:0] r_data,
  output logic [1:0]            r_resp,
  output wire                   r_last,
  input  wire                   uart_rx,
  output wire                   uart_tx
);

  localparam int TMR_W = $clog2(`UART_CLKS_PER_BIT);

  soc_pkg::bus_addr_t aw_a;
  soc_pkg::bus_addr_t ar_a;
  soc_pkg::uart_reg_t ar_reg;
  logic w_active, w_bad, w_is_tx, tx_load;
  logic tx_busy, rx_active, rx_valid, rx_clear;
  logic [9:0] tx_shift;
  logic [3:0] tx_cnt, rx_cnt;
  logic [TMR_W-1:0] tx_tmr, rx_tmr;
  logic [1:0] rx_sync;
  logic [7:0] rx_shift, rx_byte;

  assign aw_a = aw_addr;
  assign ar_a = ar_addr;
  assign ar_reg = soc_pkg::uart_reg_t'(ar_a.regs.idx);
  assign aw_ready = !w_active && !b_valid;
  assign w_ready = w_active;
  assign ar_ready = !r_valid;
  assign r_last = 1'b1;  // registers are single beat.
  assign tx_load = w_valid && w_ready && w_last && !w_bad && w_is_tx && w_strb[0] && !tx_busy;
  assign rx_clear = ar_valid && ar_ready && ar_reg == soc_pkg::RXDATA;
  assign uart_tx = tx_shift[0];

  // ######################################################################
  // register access
  // ######################################################################
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      w_active <= 1'b0;
      w_bad <= 1'b0;
      w_is_tx <= 1'b0;
      b_valid <= 1'b0;
      b_id <= '0;
      b_resp <= axi_pkg::OKAY;
    end else begin
      if (aw_valid && aw_ready) begin
        w_active <= 1'b1;
        w_bad <= aw_len != '0 || aw_burst != axi_pkg::INCR || aw_a.regs.idx == 2'd3;
        w_is_tx <= aw_a.regs.idx == soc_pkg::TXDATA;
        b_id <= aw_id;
      end
      if (w_valid && w_ready && w_last) begin
        w_active <= 1'b0;
        b_valid <= 1'b1;
        b_resp <= w_bad ? axi_pkg::SLVERR : axi_pkg::OKAY;
      end
      if (b_valid && b_ready) b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
      r_id <= '0;
      r_data <= '0;
      r_resp <= axi_pkg::OKAY;
    end else if (ar_valid && ar_ready) begin
      r_valid <= 1'b1;
      r_id <= ar_id;
      r_resp <= (ar_len != '0 || ar_burst != axi_pkg::INCR) ? axi_pkg::SLVERR
                                                             : axi_pkg::OKAY;
      case (ar_reg)
        soc_pkg::TXDATA: r_data <= '0;
        soc_pkg::RXDATA: r_data <= {56'd0, rx_byte};
        soc_pkg::STATUS: r_data <= {62'd0, rx_valid, tx_busy};
        default: begin
          r_data <= '0;
          r_resp <= axi_pkg::SLVERR;
        end
      endcase
    end else if (r_valid && r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // ######################################################################
  // 8N1 transmitter shifting out LSB first
  // ######################################################################
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      tx_shift <= '1;
      tx_cnt <= '0;
      tx_tmr <= '0;
    end else if (tx_load) begin
      tx_busy <= 1'b1;
      tx_shift <= {1'b1, w_data[7:0], 1'b0};
      tx_cnt <= '0;
      tx_tmr <= '0;
    end else if (tx_busy) begin
      tx_tmr <= tx_tmr + 1'b1;
      if (tx_tmr == TMR_W'(`UART_CLKS_PER_BIT - 1)) begin
        tx_shift <= {1'b1, tx_shift[9:1]};
        tx_cnt <= tx_cnt + 1'b1;
        if (tx_cnt == 4'd9) tx_busy <= 1'b0;  // stop bit done.
      end
    end
  end

  // ######################################################################
  // receiver
  // ######################################################################
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
      rx_active <= 1'b0;
      rx_valid <= 1'b0;
      rx_cnt <= '0;
      rx_tmr <= '0;
      rx_shift <= '0;
      rx_byte <= '0;
    end else begin
      rx_sync <= {rx_sync[0], uart_rx};
      if (rx_clear) rx_valid <= 1'b0;
      if (!rx_active) begin
        if (!rx_sync[1]) begin
          rx_active <= 1'b1;
          rx_cnt <= '0;
          rx_tmr <= TMR_W'(`UART_CLKS_PER_BIT / 2 - 1);  // to mid-bit.
        end
      end else if (rx_tmr != '0) begin
        rx_tmr <= rx_tmr - 1'b1;
      end else begin
        rx_tmr <= TMR_W'(`UART_CLKS_PER_BIT - 1);
        rx_cnt <= rx_cnt + 1'b1;
        if (rx_cnt == 4'd0 && rx_sync[1]) begin
          rx_active <= 1'b0;  // glitch rather than a start bit.
        end else if (rx_cnt == 4'd9) begin
          rx_active <= 1'b0;
          rx_byte <= rx_shift;
          rx_valid <= 1'b1;
        end else if (rx_cnt != 4'd0) begin
          rx_shift <= {rx_sync[1], rx_shift[7:1]};
        end
      end
    end
  end

  a_tx_idle_load: assert property (@(posedge clock) disable iff (!rst_n)
    tx_load |-> tx_shift == '1);

endmodule

`default_nettype wire

// File: src/heartbeat.sv
`default_nettype none

`include "soc_consts.svh"

module heartbeat #(
  parameter int half_count = `HEARTBEAT_HALF
) (
  input  wire  clock,
  input  wire  rst_n,
  output logic io
);

  logic [31:0] count;

  // wraps after half_count+1 clocks.
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
      io <= 1'b0;
    end else if (count == 32'(half_count)) begin
      count <= '0;
      io <= ~io;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/fpga_soc.sv
`default_nettype none

`include "soc_consts.svh"

module fpga_soc #(
  parameter int heartbeat_half = `HEARTBEAT_HALF
) (
  input  wire                    clock,
  input  wire                    rst_n,
  input  wire                    m_aw_valid,
  input  wire [`SOC_ID_W-1:0]    m_aw_id,
  input  wire [`SOC_ADDR_W-1:0]  m_aw_addr,
  input  wire [`SOC_LEN_W-1:0]   m_aw_len,
  input  wire [1:0]              m_aw_burst,
  output wire                    m_aw_ready,
  input  wire                    m_w_valid,
  input  wire [`SOC_DATA_W-1:0]  m_w_data,
  input  wire [`SOC_STRB_W-1:0]  m_w_strb,
  input  wire                    m_w_last,
  output wire                    m_w_ready,
  input  wire                    m_b_ready,
  output wire                    m_b_valid,
  output wire [`SOC_ID_W-1:0]    m_b_id,
  output wire [1:0]              m_b_resp,
  input  wire                    m_ar_valid,
  input  wire [`SOC_ID_W-1:0]    m_ar_id,
  input  wire [`SOC_ADDR_W-1:0]  m_ar_addr,
  input  wire [`SOC_LEN_W-1:0]   m_ar_len,
  input  wire [1:0]              m_ar_burst,
  output wire                    m_ar_ready,
  input  wire                    m_r_ready,
  output wire                    m_r_valid,
  output wire [`SOC_ID_W-1:0]    m_r_id,
  output wire [`SOC_DATA_W-1:0]  m_r_data,
  output wire [1:0]              m_r_resp,
  output wire                    m_r_last,
  input  wire                    uart_rx,
  output wire                    uart_tx,
  output wire                    io
);

  // shared downstream payloads, per-target handshakes (0 SRAM, 1 UART).
  wire [1:0] s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_ready, s_b_valid;
  wire [1:0] s_ar_valid, s_ar_ready, s_r_ready, s_r_valid, s_r_last;
  wire [`SOC_ID_W-1:0] s_aw_id, s_ar_id;
  wire [`SOC_ADDR_W-1:0] s_aw_addr, s_ar_addr;
  wire [`SOC_LEN_W-1:0] s_aw_len, s_ar_len;
  wire [1:0] s_aw_burst, s_ar_burst;
  wire [`SOC_DATA_W-1:0] s_w_data;
  wire [`SOC_STRB_W-1:0] s_w_strb;
  wire s_w_last;
  wire [2*`SOC_ID_W-1:0] s_b_id, s_r_id;
  wire [3:0] s_b_resp, s_r_resp;
  wire [2*`SOC_DATA_W-1:0] s_r_data;

  axi_addr_decoder u_decoder (.*);

  axi_sram u_sram (
    .clock(clock), .rst_n(rst_n),
    .aw_valid(s_aw_valid[0]), .aw_id(s_aw_id), .aw_addr(s_aw_addr),
    .aw_len(s_aw_len), .aw_burst(s_aw_burst), .aw_ready(s_aw_ready[0]),
    .w_valid(s_w_valid[0]), .w_data(s_w_data), .w_strb(s_w_strb),
    .w_last(s_w_last), .w_ready(s_w_ready[0]),
    .b_ready(s_b_ready[0]), .b_valid(s_b_valid[0]),
    .b_id(s_b_id[0 +: `SOC_ID_W]), .b_resp(s_b_resp[1:0]),
    .ar_valid(s_ar_valid[0]), .ar_id(s_ar_id), .ar_addr(s_ar_addr),
    .ar_len(s_ar_len), .ar_burst(s_ar_burst), .ar_ready(s_ar_ready[0]),
    .r_ready(s_r_ready[0]), .r_valid(s_r_valid[0]), .r_id(s_r_id[0 +: `SOC_ID_W]),
    .r_data(s_r_data[0 +: `SOC_DATA_W]), .r_resp(s_r_resp[1:0]), .r_last(s_r_last[0])
  );

  axi_uart u_uart (
    .clock(clock), .rst_n(rst_n),
    .aw_valid(s_aw_valid[1]), .aw_id(s_aw_id), .aw_addr(s_aw_addr),
    .aw_len(s_aw_len), .aw_burst(s_aw_burst), .aw_ready(s_aw_ready[1]),
    .w_valid(s_w_valid[1]), .w_data(s_w_data), .w_strb(s_w_strb),
    .w_last(s_w_last), .w_ready(s_w_ready[1]),
    .b_ready(s_b_ready[1]), .b_valid(s_b_valid[1]),
    .b_id(s_b_id[`SOC_ID_W +: `SOC_ID_W]), .b_resp(s_b_resp[3:2]),
    .ar_valid(s_ar_valid[1]), .ar_id(s_ar_id), .ar_addr(s_ar_addr),
    .ar_len(s_ar_len), .ar_burst(s_ar_burst), .ar_ready(s_ar_ready[1]),
    .r_ready(s_r_ready[1]), .r_valid(s_r_valid[1]),
    .r_id(s_r_id[`SOC_ID_W +: `SOC_ID_W]), .r_data(s_r_data[`SOC_DATA_W +: `SOC_DATA_W]),
    .r_resp(s_r_resp[3:2]), .r_last(s_r_last[1]),
    .uart_rx(uart_rx), .uart_tx(uart_tx)
  );

  heartbeat #(.half_count(heartbeat_half)) u_heartbeat (
    .clock(clock),
    .rst_n(rst_n),
    .io(io)
  );

endmodule

`default_nettype wire

// File: sim/tb_fpga_soc.sv
`default_nettype none

`include "soc_consts.svh"

module tb_fpga_soc;

  localparam int HALF_PERIOD = 50;
  localparam int SETTLE = HALF_PERIOD / 5;
  localparam int HB_HALF = 20;
  localparam int OP_WRITE = 0;
  localparam int OP_READ = 1;
  localparam int OP_UART = 2;
  localparam int OP_IDLE = 3;
  localparam logic [`SOC_ID_W-1:0] WR_ID = 4'h3;
  localparam logic [`SOC_ID_W-1:0] RD_ID = 4'h5;

  logic clock, rst_n;
  logic m_aw_valid, m_w_valid, m_w_last, m_b_ready, m_ar_valid, m_r_ready;
  logic [`SOC_ID_W-1:0] m_aw_id, m_ar_id;
  logic [`SOC_ADDR_W-1:0] m_aw_addr, m_ar_addr;
  logic [`SOC_LEN_W-1:0] m_aw_len, m_ar_len;
  logic [1:0] m_aw_burst, m_ar_burst;
  logic [`SOC_DATA_W-1:0] m_w_data;
  logic [`SOC_STRB_W-1:0] m_w_strb;
  wire m_aw_ready, m_w_ready, m_b_valid, m_ar_ready, m_r_valid, m_r_last;
  wire [`SOC_ID_W-1:0] m_b_id, m_r_id;
  wire [1:0] m_b_resp, m_r_resp;
  wire [`SOC_DATA_W-1:0] m_r_data;
  wire serial;  // tx looped back to rx.
  wire io;

  // stimulus table, one entry per index.
  int unsigned op_kind [$];
  logic [31:0] op_addr [$];
  int unsigned op_len [$];
  logic [7:0] op_strb [$];
  logic [63:0] op_data [$];
  logic [1:0] op_resp [$];

  logic [63:0] ref_mem [`SRAM_WORDS];
  logic [63:0] beat_data [16];
  logic [63:0] rd_data [16];
  logic [1:0] rd_resp [16];
  logic rd_last [16];
  logic [`SOC_ID_W-1:0] rd_id [16];
  int rd_count;
  logic [31:0] lcg_state = 32'h1dee_8088;
  int test_errors, pass_count, fail_count;
  int cycles, cycle_limit;

  fpga_soc #(.heartbeat_half(HB_HALF)) u_fpga_soc (.*, .uart_rx(serial), .uart_tx(serial));

  initial clock = 1'b0;
  always #HALF_PERIOD clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ######################################################################
  // helpers
  // ######################################################################
  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function logic [63:0] data_word();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic logic [7:0] rotate_strb(input logic [7:0] s, input int n);
    logic [15:0] d;
    d = {s, s} << (n % 8);
    return d[15:8];
  endfunction

  function automatic string kind_name(input int unsigned kind);
    case (kind)
      OP_WRITE: return "write";
      OP_READ: return "read";
      OP_UART: return "uart send";
      default: return "idle";
    endcase
  endfunction

  task automatic add_op(input int unsigned kind, input logic [31:0] addr, input int unsigned len,
                        input logic [7:0] strb, input logic [1:0] resp);
    op_kind.push_back(kind);
    op_addr.push_back(addr);
    op_len.push_back(len);
    op_strb.push_back(strb);
    op_data.push_back(data_word());
    op_resp.push_back(resp);
  endtask

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] got);
    assert (got === expected) else begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
      test_errors++;
    end
  endtask

  task automatic finish_test(input int idx, input string name);
    if (test_errors == 0) pass_count++;
    else fail_count++;
    $display("test %0d %s: %s", idx, name, test_errors == 0 ? "ok" : "errors");
  endtask

  // ######################################################################
  // bus master
  // ######################################################################
  task automatic send_write(input logic [31:0] addr, input int beats, input logic [7:0] strb,
                            output logic [1:0] resp);
    int b;
    @(negedge clock);
    m_aw_valid = 1'b1;
    m_aw_id = WR_ID;
    m_aw_addr = addr;
    m_aw_len = 8'(beats - 1);
    m_aw_burst = axi_pkg::INCR;
    #SETTLE;
    while (!m_aw_ready) begin
      @(negedge clock);
      #SETTLE;
    end
    for (b = 0; b < beats; b++) begin
      @(negedge clock);
      m_aw_valid = 1'b0;
      m_w_valid = 1'b1;
      m_w_data = beat_data[b];
      m_w_strb = rotate_strb(strb, b);
      m_w_last = (b == beats - 1);
      #SETTLE;
      while (!m_w_ready) begin
        @(negedge clock);
        #SETTLE;
      end
    end
    @(negedge clock);
    m_w_valid = 1'b0;
    m_w_last = 1'b0;
    m_b_ready = 1'b1;
    #SETTLE;
    while (!m_b_valid) begin
      @(negedge clock);
      #SETTLE;
    end
    resp = m_b_resp;
    check_val("m_b_id", WR_ID, m_b_id);
    @(negedge clock);
    m_b_ready = 1'b0;
  endtask

  // collects beats up to rlast with rready toggling randomly under stall.
  task automatic send_read(input logic [31:0] addr, input int beats, input bit stall);
    logic [31:0] rnd;
    bit done;
    @(negedge clock);
    m_ar_valid = 1'b1;
    m_ar_id = RD_ID;
    m_ar_addr = addr;
    m_ar_len = 8'(beats - 1);
    m_ar_burst = axi_pkg::INCR;
    #SETTLE;
    while (!m_ar_ready) begin
      @(negedge clock);
      #SETTLE;
    end
    rd_count = 0;
    done = 1'b0;
    @(negedge clock);
    m_ar_valid = 1'b0;
    while (!done) begin
      rnd = lcg_next();
      m_r_ready = rnd[9] || !stall;
      #SETTLE;
      if (m_r_valid && m_r_ready) begin
        rd_data[rd_count] = m_r_data;
        rd_resp[rd_count] = m_r_resp;
        rd_last[rd_count] = m_r_last;
        rd_id[rd_count] = m_r_id;
        rd_count++;
        done = m_r_last || rd_count == 16;
      end
      @(negedge clock);
    end
    m_r_ready = 1'b0;
  endtask

  // ######################################################################
  // main sequence
  // ######################################################################
  initial begin
    int i, b, k;
    logic [1:0] resp;
    logic [63:0] exp_data, status;
    logic [7:0] lanes, idx;
    int gap;
    logic last_io;

    add_op(OP_WRITE, 32'h8000_0040, 4, 8'hff, axi_pkg::OKAY);  // prefill.
    add_op(OP_WRITE, 32'h8000_0040, 4, 8'h5a, axi_pkg::OKAY);
    add_op(OP_READ, 32'h8000_0040, 4, 8'h00, axi_pkg::OKAY);
    add_op(OP_WRITE, 32'hf000_0000, 2, 8'hff, axi_pkg::DECERR);
    add_op(OP_READ, 32'hf000_0100, 3, 8'h00, axi_pkg::DECERR);
    add_op(OP_UART, 32'h1000_0000, 1, 8'h01, axi_pkg::OKAY);
    add_op(OP_WRITE, 32'h1000_0000, 2, 8'h01, axi_pkg::SLVERR);
    add_op(OP_READ, 32'h1000_0018, 1, 8'h00, axi_pkg::SLVERR);  // register index 3.
    add_op(OP_IDLE, 32'h0, 3, 8'h00, axi_pkg::OKAY);  // heartbeat periods.

    cycle_limit = 200 + 4 * 10 * `UART_CLKS_PER_BIT;
    foreach (op_kind[n]) begin
      if (op_kind[n] == OP_IDLE) cycle_limit += (op_len[n] + 1) * (HB_HALF + 1);
      else cycle_limit += 8 * op_len[n] + 8;
    end

    cycles = 0;
    pass_count = 0;
    fail_count = 0;
    rst_n = 1'b0;
    m_aw_valid = 1'b0;
    m_aw_id = '0;
    m_aw_addr = '0;
    m_aw_len = '0;
    m_aw_burst = '0;
    m_w_valid = 1'b0;
    m_w_data = '0;
    m_w_strb = '0;
    m_w_last = 1'b0;
    m_b_ready = 1'b0;
    m_ar_valid = 1'b0;
    m_ar_id = '0;
    m_ar_addr = '0;
    m_ar_len = '0;
    m_ar_burst = '0;
    m_r_ready = 1'b0;
    repeat (4) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);

    test_errors = 0;
    check_val("io", 0, io);
    check_val("uart_tx", 1, serial);
    check_val("m_b_valid", 0, m_b_valid);
    check_val("m_r_valid", 0, m_r_valid);
    check_val("m_aw_ready", 1, m_aw_ready);
    check_val("m_ar_ready", 1, m_ar_ready);
    finish_test(0, "reset");

    for (i = 0; i < op_kind.size(); i++) begin
      test_errors = 0;
      case (op_kind[i])
        OP_WRITE: begin
          beat_data[0] = op_data[i];
          for (b = 1; b < op_len[i]; b++) beat_data[b] = data_word();
          send_write(op_addr[i], op_len[i], op_strb[i], resp);
          check_val("m_b_resp", op_resp[i], resp);
          if (op_addr[i][31:28] == `REGION_SRAM && op_resp[i] == axi_pkg::OKAY) begin
            for (b = 0; b < op_len[i]; b++) begin
              lanes = rotate_strb(op_strb[i], b);
              idx = 8'(op_addr[i][10:3] + b);
              for (k = 0; k < 8; k++)
                if (lanes[k]) ref_mem[idx][8*k +: 8] = beat_data[b][8*k +: 8];
            end
          end
        end
        OP_READ: begin
          send_read(op_addr[i], op_len[i], 1'b1);
          check_val("read beat count", op_len[i], rd_count);
          for (b = 0; b < rd_count; b++) begin
            idx = 8'(op_addr[i][10:3] + b);
            exp_data = (op_addr[i][31:28] == `REGION_SRAM) ? ref_mem[idx] : '0;
            check_val("m_r_data", exp_data, rd_data[b]);
            check_val("m_r_resp", op_resp[i], rd_resp[b]);
            check_val("m_r_last", b == op_len[i] - 1, rd_last[b]);
            check_val("m_r_id", RD_ID, rd_id[b]);
          end
        end
        OP_UART: begin
          beat_data[0] = op_data[i];
          send_write(op_addr[i], 1, op_strb[i], resp);
          check_val("m_b_resp", op_resp[i], resp);
          status = '0;
          while (!status[1]) begin
            send_read(op_addr[i] + 32'h10, 1, 1'b0);
            check_val("status m_r_resp", axi_pkg::OKAY, rd_resp[0]);
            status = rd_data[0];
          end
          send_read(op_addr[i] + 32'h8, 1, 1'b0);
          check_val("rx byte", {56'd0, op_data[i][7:0]}, rd_data[0]);
          check_val("rx m_r_resp", axi_pkg::OKAY, rd_resp[0]);
          send_read(op_addr[i] + 32'h10, 1, 1'b0);
          check_val("rx_valid after read", 0, rd_data[0][1]);
        end
        default: begin
          // io toggles every half_count+1 clocks.
          @(negedge clock);
          last_io = io;
          while (io == last_io) @(negedge clock);
          for (b = 0; b < op_len[i]; b++) begin
            last_io = io;
            gap = 0;
            while (io == last_io) begin
              @(negedge clock);
              gap++;
            end
            check_val("io half period", HB_HALF + 1, gap);
          end
        end
      endcase
      finish_test(i + 1, kind_name(op_kind[i]));
    end

    @(negedge clock);
    $display("tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
             pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
src/axi_pkg.sv
src/soc_pkg.sv
src/axi_addr_decoder.sv
src/axi_sram.sv
src/axi_uart.sv
src/heartbeat.sv
src/fpga_soc.sv
sim/tb_fpga_soc.sv
